//--- source/link_pkg.sv
/* link status package
   MAC status nibble, receive flag pulses and error counter word */
`default_nettype none

package link_pkg;

    //--------------------------------------------------
    // MAC status nibble
    //--------------------------------------------------
    typedef struct packed {
        logic       spare;      // bit 3, unused by the MAC
        logic [1:0] speed;      // bits 2:1
        logic       link_up;    // bit 0
    } link_status_t;

    localparam logic [1:0] SPEED_10   = 2'b00;
    localparam logic [1:0] SPEED_100  = 2'b01;
    localparam logic [1:0] SPEED_1G   = 2'b10;

    // single-cycle pulses from the receive MAC
    typedef struct packed {
        logic bad;  // bad frame
        logic err;  // receive error
    } rx_flags_t;

    typedef logic [31:0] err_count_t;

endpackage

`default_nettype wire

//--- source/stream_pkg.sv
/* byte stream package
   one beat of the test byte stream and the numbered frame pattern */
`default_nettype none

package stream_pkg;

    //--------------------------------------------------
    // byte beat, 11 bits
    //--------------------------------------------------
    typedef struct packed {
        logic       valid;
        logic       sof;    // first byte of a frame
        logic       eof;    // last byte of a frame
        logic [7:0] data;
    } byte_beat_t;

    typedef logic [7:0] frame_idx_t;

    // byte k of frame n carries (n + k) mod 256
    function automatic logic [7:0] pattern_byte(
        input frame_idx_t frame,
        input logic [7:0] pos
    );
        logic [7:0] sum;
        sum = frame + pos;  // wraps at 256
        return sum;
    endfunction

endpackage

`default_nettype wire

//--- source/link_qualifier.sv
/* link qualifier
   flags a port ready only while its link is up at 1 Gb/s */
`timescale 1ns/1ps
`default_nettype none

module link_qualifier
    import link_pkg::*;
#(
    parameter int NUM_PORTS = 4    // up to 4
) (
    input  wire logic                          clk20_g,
    input  wire logic                          rst_i,
    input  wire link_status_t [NUM_PORTS-1:0]  status_i,
    output logic [NUM_PORTS-1:0]               ready_o
);

    //--------------------------------------------------
    // status decode, one register per port
    //--------------------------------------------------
    logic [NUM_PORTS-1:0] ready_next;

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            // 10 and 100 Mb/s links are not usable for the test
            ready_next[p] = status_i[p].link_up && (status_i[p].speed == SPEED_1G);
        end
    end

    always_ff @(posedge clk20_g) begin
        if (rst_i) begin
            ready_o <= '0;
        end else begin
            ready_o <= ready_next;
        end
    end

endmodule

`default_nettype wire

//--- source/rx_error_counter.sv
/* receive error counters
   one 32-bit count of bad and errored frames per port, zero while not ready */
`timescale 1ns/1ps
`default_nettype none

module rx_error_counter
    import link_pkg::*;
#(
    parameter int NUM_PORTS = 4
) (
    input  wire logic                          clk20_g,
    input  wire logic                          rst_i,
    input  wire logic [NUM_PORTS-1:0]          ready_i,
    input  wire rx_flags_t [NUM_PORTS-1:0]     flags_i,
    output err_count_t [NUM_PORTS-1:0]         count_o
);

    logic [NUM_PORTS-1:0] hit;  // any flag this cycle

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            hit[p] = flags_i[p].bad | flags_i[p].err;  // both at once counts once
        end
    end

    //--------------------------------------------------
    // counters
    //--------------------------------------------------
    always_ff @(posedge clk20_g) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (rst_i || !ready_i[p]) begin
                count_o[p] <= '0;   // held clear while the link is unusable
            end else if (hit[p]) begin
                count_o[p] <= count_o[p] + 32'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/test_frame_gen.sv
/* test frame generator
   sends numbered pattern frames while start is high, paced by returned credits */
`timescale 1ns/1ps
`default_nettype none

module test_frame_gen
    import stream_pkg::*;
#(
    parameter int FRAME_LEN  = 16,  // at least 2
    parameter int TX_CREDITS = 4
) (
    input  wire logic clk20_g,
    input  wire logic rst_i,
    input  wire logic start_i,
    input  wire logic credit_i,     // one byte slot returned
    output byte_beat_t tx_o
);

    localparam int CW = $clog2(TX_CREDITS + 1);
    localparam int PW = $clog2(FRAME_LEN);
    localparam logic [PW-1:0] LAST_POS = PW'(FRAME_LEN - 1);

    logic [CW-1:0] credit_cnt;
    logic [PW-1:0] byte_pos;
    frame_idx_t    frame_num;
    logic          send;
    logic          last_byte;

    // a started frame runs to its end even if start drops
    assign send      = (credit_cnt != '0) && (start_i || (byte_pos != '0));
    assign last_byte = (byte_pos == LAST_POS);

    //--------------------------------------------------
    // credit count
    //--------------------------------------------------
    always_ff @(posedge clk20_g) begin
        if (rst_i) begin
            credit_cnt <= CW'(TX_CREDITS);
        end else begin
            case ({send, credit_i})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;  // none, or byte and credit together
            endcase
        end
    end

    //--------------------------------------------------
    // position, frame number and output beat
    //--------------------------------------------------
    always_ff @(posedge clk20_g) begin
        if (rst_i) begin
            byte_pos  <= '0;
            frame_num <= '0;
            tx_o      <= '0;
        end else begin
            tx_o.valid <= send;
            tx_o.sof   <= send && (byte_pos == '0);
            tx_o.eof   <= send && last_byte;
            tx_o.data  <= pattern_byte(frame_num, 8'(byte_pos));
            if (send) begin
                if (last_byte) begin
                    byte_pos  <= '0;
                    frame_num <= frame_num + 8'd1;
                end else begin
                    byte_pos <= byte_pos + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/test_frame_checker.sv
/* loopback frame checker
   compares received bytes with the frame pattern, latches the first mismatch */
`timescale 1ns/1ps
`default_nettype none

module test_frame_checker
    import stream_pkg::*;
#(
    parameter int FRAME_LEN = 16
) (
    input  wire logic       clk20_g,
    input  wire logic       rst_i,
    input  wire byte_beat_t rx_i,
    output logic            err_o,          // sticky until reset
    output frame_idx_t      good_frames_o
);

    localparam int PW = $clog2(FRAME_LEN);
    localparam logic [PW-1:0] LAST_POS = PW'(FRAME_LEN - 1);

    logic [PW-1:0] exp_pos;
    frame_idx_t    exp_frame;
    logic          exp_last;
    logic          mismatch;

    assign exp_last = (exp_pos == LAST_POS);

    // data, sof and eof must all agree with the expected position
    always_comb begin
        mismatch = 1'b0;
        if (rx_i.valid) begin
            mismatch = (rx_i.data != pattern_byte(exp_frame, 8'(exp_pos)))
                    || (rx_i.sof != (exp_pos == '0))
                    || (rx_i.eof != exp_last);
        end
    end

    //--------------------------------------------------
    // tracking and result
    //--------------------------------------------------
    always_ff @(posedge clk20_g) begin
        if (rst_i) begin
            exp_pos       <= '0;
            exp_frame     <= '0;
            err_o         <= 1'b0;
            good_frames_o <= '0;
        end else if (rx_i.valid) begin
            if (mismatch) err_o <= 1'b1;
            if (exp_last) begin
                exp_pos   <= '0;
                exp_frame <= exp_frame + 8'd1;
                // a frame after the first error never counts as good
                if (!mismatch && !err_o) good_frames_o <= good_frames_o + 8'd1;
            end else begin
                exp_pos <= exp_pos + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/led_blinker.sv
/* debug LED blinker
   toggles every BLINK_HALF cycles, dark once the loopback test fails */
`timescale 1ns/1ps
`default_nettype none

module led_blinker #(
    parameter int BLINK_HALF = 25   // half period in clk20_g cycles
) (
    input  wire logic clk20_g,
    input  wire logic rst_i,
    input  wire logic err_i,
    output logic      led_o
);

    localparam int DW = (BLINK_HALF > 1) ? $clog2(BLINK_HALF) : 1;

    logic [DW-1:0] div_cnt;
    logic          blink;

    always_ff @(posedge clk20_g) begin
        if (rst_i) begin
            div_cnt <= '0;
            blink   <= 1'b0;
        end else if (div_cnt == DW'(BLINK_HALF - 1)) begin
            div_cnt <= '0;
            blink   <= ~blink;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign led_o = blink & ~err_i;  // error wins at once

endmodule

`default_nettype wire

//--- source/eth_test_top.sv
/* Ethernet test path top level
   link qualification, error counters, loopback frame test and debug LED */
`timescale 1ns/1ps
`default_nettype none

module eth_test_top
    import link_pkg::*;
    import stream_pkg::*;
#(
    parameter int NUM_PORTS  = 4,   // up to 4
    parameter int FRAME_LEN  = 16,
    parameter int TX_CREDITS = 4,
    parameter int BLINK_HALF = 25
) (
    input  wire logic                          clk20_g,
    input  wire logic                          rst_i,
    input  wire logic                          start_i,
    input  wire logic                          tx_credit_i,
    input  wire byte_beat_t                    rx_i,
    input  wire link_status_t [NUM_PORTS-1:0]  port_status_i,
    input  wire rx_flags_t [NUM_PORTS-1:0]     port_rx_flags_i,
    output byte_beat_t                         tx_o,
    output logic [NUM_PORTS-1:0]               port_ready_o,
    output err_count_t [NUM_PORTS-1:0]         err_count_o,
    output logic                               test_err_o,
    output frame_idx_t                         good_frames_o,
    output logic                               led_o
);

    //--------------------------------------------------
    // per-port link status
    //--------------------------------------------------
    link_qualifier #(.NUM_PORTS(NUM_PORTS)) u_qual (
        .clk20_g (clk20_g),
        .rst_i   (rst_i),
        .status_i(port_status_i),
        .ready_o (port_ready_o)
    );

    rx_error_counter #(.NUM_PORTS(NUM_PORTS)) u_cnterr (
        .clk20_g(clk20_g),
        .rst_i  (rst_i),
        .ready_i(port_ready_o),     // counts only on 1G links
        .flags_i(port_rx_flags_i),
        .count_o(err_count_o)
    );

    //--------------------------------------------------
    // loopback test
    //--------------------------------------------------
    test_frame_gen #(.FRAME_LEN(FRAME_LEN), .TX_CREDITS(TX_CREDITS)) u_gen (
        .clk20_g (clk20_g),
        .rst_i   (rst_i),
        .start_i (start_i),
        .credit_i(tx_credit_i),
        .tx_o    (tx_o)
    );

    test_frame_checker #(.FRAME_LEN(FRAME_LEN)) u_chk (
        .clk20_g      (clk20_g),
        .rst_i        (rst_i),
        .rx_i         (rx_i),
        .err_o        (test_err_o),
        .good_frames_o(good_frames_o)
    );

    led_blinker #(.BLINK_HALF(BLINK_HALF)) u_led (
        .clk20_g(clk20_g),
        .rst_i  (rst_i),
        .err_i  (test_err_o),
        .led_o  (led_o)
    );

endmodule

`default_nettype wire

//--- sim/tb_eth_test.sv
/* testbench for the Ethernet test path
   replays the trace, acts as the MAC on the loopback and checks the results */
`timescale 1ns/1ps
`default_nettype none

module tb_eth_test
    import link_pkg::*;
    import stream_pkg::*;
();

    localparam int NUM_PORTS  = 4;
    localparam int FRAME_LEN  = 16;
    localparam int TX_CREDITS = 4;
    localparam int BLINK_HALF = 25;
    localparam int MAX_TESTS  = 16;

    logic                         clk20_g;
    logic                         rst_i;
    logic                         start_i;
    logic                         tx_credit_i;
    byte_beat_t                   rx_i;
    byte_beat_t                   tx_o;
    link_status_t [NUM_PORTS-1:0] port_status_i;
    rx_flags_t [NUM_PORTS-1:0]    port_rx_flags_i;
    logic [NUM_PORTS-1:0]         port_ready_o;
    err_count_t [NUM_PORTS-1:0]   err_count_o;
    logic                         test_err_o;
    frame_idx_t                   good_frames_o;
    logic                         led_o;

    // one entry per trace line
    string t_name[MAX_TESTS];
    int    t_status[MAX_TESTS][NUM_PORTS];
    int    t_bad[MAX_TESTS][NUM_PORTS];
    int    t_err[MAX_TESTS][NUM_PORTS];
    int    t_cnt[MAX_TESTS][NUM_PORTS];
    int    t_frames[MAX_TESTS];
    int    t_corrupt[MAX_TESTS];    // stream byte index or -1 when none
    int    t_delay[MAX_TESTS];
    int    t_rdy[MAX_TESTS];
    int    t_good[MAX_TESTS];
    int    t_terr[MAX_TESTS];
    int    num_tests;
    string cur_name;
    int    cycle_cnt = 0;
    int    cycle_limit = 0;
    logic [31:0] rng_state;

    eth_test_top #(
        .NUM_PORTS (NUM_PORTS),
        .FRAME_LEN (FRAME_LEN),
        .TX_CREDITS(TX_CREDITS),
        .BLINK_HALF(BLINK_HALF)
    ) dut (
        .clk20_g        (clk20_g),
        .rst_i          (rst_i),
        .start_i        (start_i),
        .tx_credit_i    (tx_credit_i),
        .rx_i           (rx_i),
        .port_status_i  (port_status_i),
        .port_rx_flags_i(port_rx_flags_i),
        .tx_o           (tx_o),
        .port_ready_o   (port_ready_o),
        .err_count_o    (err_count_o),
        .test_err_o     (test_err_o),
        .good_frames_o  (good_frames_o),
        .led_o          (led_o)
    );

    initial begin
        clk20_g = 1'b0;
        forever #20 clk20_g = ~clk20_g;    // 25 MHz stand-in for the 20 ns board clock pair
    end

    always @(posedge clk20_g) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            stop_failed($sformatf("run passed %0d cycles in test %s", cycle_limit, cur_name));
        end
    end

    // --------------------------------------------------
    // result checks
    // --------------------------------------------------
    task automatic stop_failed(input string reason);
        $display("sim failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_ready(input string what, input logic [NUM_PORTS-1:0] exp_v,
                               input logic [NUM_PORTS-1:0] act_v);
        if (act_v !== exp_v) begin
            $display("ERR %s %s: expected %h, actual %h", cur_name, what, exp_v, act_v);
            stop_failed("port ready flags wrong");
        end
    endtask

    task automatic check_count(input string what, input err_count_t exp_v,
                               input err_count_t act_v);
        if (act_v !== exp_v) begin
            $display("ERR %s %s: expected %0d, actual %0d", cur_name, what, exp_v, act_v);
            stop_failed("error count wrong");
        end
    endtask

    task automatic check_frames(input string what, input frame_idx_t exp_v,
                                input frame_idx_t act_v);
        if (act_v !== exp_v) begin
            $display("ERR %s %s: expected %0d, actual %0d", cur_name, what, exp_v, act_v);
            stop_failed("good frame count wrong");
        end
    endtask

    task automatic check_err(input string what, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("ERR %s %s: expected %b, actual %b", cur_name, what, exp_v, act_v);
            stop_failed("flag wrong");
        end
    endtask

    task automatic check_beat(input string what, input byte_beat_t exp_v,
                              input byte_beat_t act_v);
        if (act_v !== exp_v) begin
            $display("ERR %s %s: expected %h, actual %h", cur_name, what, exp_v, act_v);
            stop_failed("tx byte does not follow the frame pattern");
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // --------------------------------------------------
    // trace and test phases
    // --------------------------------------------------
    task automatic read_trace();
        int    fd;
        int    n;
        int    k;
        string line;
        fd = $fopen("sim/eth_test_trace.txt", "r");
        if (fd == 0) stop_failed("could not open the trace file sim/eth_test_trace.txt");
        num_tests = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line.substr(0, 0) == "#") continue;
            if (num_tests >= MAX_TESTS) stop_failed("trace holds too many tests");
            k = num_tests;
            n = $sscanf(line,
                "%s %h %h %h %h %d %d %d %d %d %d %d %d %d %d %d %h %d %d %d %d %d %d",
                t_name[k], t_status[k][0], t_status[k][1], t_status[k][2], t_status[k][3],
                t_bad[k][0], t_bad[k][1], t_bad[k][2], t_bad[k][3],
                t_err[k][0], t_err[k][1], t_err[k][2], t_err[k][3],
                t_frames[k], t_corrupt[k], t_delay[k], t_rdy[k],
                t_cnt[k][0], t_cnt[k][1], t_cnt[k][2], t_cnt[k][3], t_good[k], t_terr[k]);
            if (n != 23) stop_failed($sformatf("trace line %0d is malformed", k + 1));
            num_tests++;
        end
        $fclose(fd);
    endtask

    task automatic reset_dut();
        rst_i           = 1'b1;
        start_i         = 1'b0;
        tx_credit_i     = 1'b0;
        rx_i            = '0;
        port_status_i   = '0;
        port_rx_flags_i = '0;
        repeat (8) @(negedge clk20_g);
        rst_i = 1'b0;
        @(negedge clk20_g);
        check_ready("ready after reset", '0, port_ready_o);
        check_err("tx valid after reset", 1'b0, tx_o.valid);
        check_err("test_err after reset", 1'b0, test_err_o);
        check_err("led after reset", 1'b0, led_o);
        check_frames("good frames after reset", '0, good_frames_o);
        for (int p = 0; p < NUM_PORTS; p++) check_count("count after reset", '0, err_count_o[p]);
    endtask

    // bad pulses first, then err pulses, one slot per cycle with random idle gaps
    task automatic run_pulses(input int t);
        int slots;
        int gap;
        slots = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (t_bad[t][p] + t_err[t][p] > slots) slots = t_bad[t][p] + t_err[t][p];
        end
        for (int s = 0; s < slots; s++) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                port_rx_flags_i[p].bad = (s < t_bad[t][p]);
                port_rx_flags_i[p].err = (s >= t_bad[t][p]) && (s < t_bad[t][p] + t_err[t][p]);
            end
            @(negedge clk20_g);
            port_rx_flags_i = '0;
            rng_state = lcg_next(rng_state);
            gap = int'(rng_state[17:16]);
            repeat (gap) @(negedge clk20_g);
        end
        repeat (2) @(negedge clk20_g);
    endtask

    // MAC model that queues tx bytes, gives credits back after the delay and loops bytes to rx
    task automatic run_frames(input int t);
        int         total, sent, credited, replayed, sofs;
        int         due_q[$];
        byte_beat_t rx_q[$];
        byte_beat_t beat;
        byte_beat_t exp_beat;
        total    = t_frames[t] * FRAME_LEN;
        sent     = 0;
        credited = 0;
        replayed = 0;
        sofs     = 0;
        start_i  = (total > 0);
        while (replayed < total || credited < total) begin
            @(negedge clk20_g);
            tx_credit_i = 1'b0;
            rx_i        = '0;
            if (tx_o.valid) begin
                if (sent >= total) stop_failed("generator sent more bytes than requested");
                if (sent + 1 - credited > TX_CREDITS) begin
                    stop_failed("more bytes in flight than credits");
                end
                // frame n = sent / FRAME_LEN, byte k = sent % FRAME_LEN
                exp_beat.valid = 1'b1;
                exp_beat.sof   = (sent % FRAME_LEN == 0);
                exp_beat.eof   = (sent % FRAME_LEN == FRAME_LEN - 1);
                exp_beat.data  = 8'(sent / FRAME_LEN + sent % FRAME_LEN);
                check_beat($sformatf("tx byte %0d", sent), exp_beat, tx_o);
                sent++;
                if (tx_o.sof) sofs++;
                if (sofs == t_frames[t]) start_i = 1'b0;   // last frame has begun
                due_q.push_back(cycle_cnt + t_delay[t]);
                rx_q.push_back(tx_o);
            end
            if (due_q.size() > 0 && due_q[0] <= cycle_cnt) begin
                due_q.delete(0);
                tx_credit_i = 1'b1;
                credited++;
            end
            if (rx_q.size() > 0) begin
                beat = rx_q.pop_front();
                if (replayed == t_corrupt[t]) beat.data = ~beat.data;
                rx_i = beat;
                replayed++;
            end
        end
        @(negedge clk20_g);
        rx_i        = '0;
        tx_credit_i = 1'b0;
        @(negedge clk20_g);
    endtask

    task automatic watch_led(input int t);
        logic prev;
        int   toggles;
        prev    = led_o;
        toggles = 0;
        repeat (2 * BLINK_HALF + 2) begin
            @(negedge clk20_g);
            if (led_o !== prev) toggles++;
            if (t_terr[t] != 0 && led_o !== 1'b0) stop_failed("led lit after a test error");
            prev = led_o;
        end
        if (t_terr[t] == 0 && toggles == 0) stop_failed("led did not blink without an error");
    endtask

    initial begin
        rst_i           = 1'b1;
        start_i         = 1'b0;
        tx_credit_i     = 1'b0;
        rx_i            = '0;
        port_status_i   = '0;
        port_rx_flags_i = '0;
        rng_state       = 32'hb001e294;
        cur_name        = "setup";
        read_trace();
        for (int t = 0; t < num_tests; t++) begin
            cycle_limit += t_frames[t] * FRAME_LEN * (t_delay[t] + 2) + 200;
        end
        for (int t = 0; t < num_tests; t++) begin
            cur_name = t_name[t];
            reset_dut();
            for (int p = 0; p < NUM_PORTS; p++) begin
                port_status_i[p] = link_status_t'(t_status[t][p][3:0]);
            end
            repeat (2) @(negedge clk20_g);
            check_ready("port ready", t_rdy[t][NUM_PORTS-1:0], port_ready_o);
            run_pulses(t);
            for (int p = 0; p < NUM_PORTS; p++) begin
                check_count($sformatf("count port %0d", p), err_count_t'(t_cnt[t][p]),
                            err_count_o[p]);
            end
            run_frames(t);
            check_frames("good frames", frame_idx_t'(t_good[t]), good_frames_o);
            check_err("test_err", t_terr[t][0], test_err_o);
            watch_led(t);
        end
        if (num_tests == 0) begin
            stop_failed("trace holds no tests");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- project.f
source/link_pkg.sv
source/stream_pkg.sv
source/link_qualifier.sv
source/rx_error_counter.sv
source/test_frame_gen.sv
source/test_frame_checker.sv
source/led_blinker.sv
source/eth_test_top.sv
sim/tb_eth_test.sv

//--- Makefile
SIM   := verilator
FLAGS := --binary --timing -j 0 -Wno-fatal
TOP   := tb_eth_test
FLIST := project.f
PASS  := sim passed

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf obj_dir

//--- sim/eth_test_trace.txt
# name st0 st1 st2 st3 (hex) bad0..bad3 err0..err3 frames corrupt(-1 none) delay
#   rdy (hex mask) cnt0..cnt3 good terr
all_1g        5 5 5 5  2 0 1 3  1 2 0 0  2 -1 0   f  3 2 1 3  2 0
mixed_speed   5 3 1 4  2 2 2 2  1 1 1 1  3 -1 2   1  3 0 0 0  3 0
spare_bit     d 7 0 5  0 1 4 2  3 1 0 0  1 -1 1   9  3 0 0 2  1 0
slow_credit   5 5 4 3  1 0 2 0  0 1 0 2  4 -1 12  3  1 1 0 0  4 0
corrupt_mid   5 0 0 0  0 0 0 0  0 0 0 0  3 20 0   1  0 0 0 0  1 1
corrupt_first 4 5 0 0  1 1 0 0  0 0 0 0  2 0 3    2  0 1 0 0  0 1
corrupt_last  5 5 5 5  0 0 0 0  0 0 0 0  2 31 1   f  0 0 0 0  1 1
long_run      1 1 1 1  3 3 3 3  0 0 0 0  6 -1 5   0  0 0 0 0  6 0
